// ==== common/os_gen_macros.svh ====
`ifndef OS_GEN_MACROS_SVH
`define OS_GEN_MACROS_SVH

// link width and PIPE width
`define OSG_LANES        4
`define OSG_SYMS_PER_CLK 2   // 1, 2 or 4 for an 8, 16 or 32 bit PIPE

// ordered set lengths in symbols
`define OSG_TS_LEN    16
`define OSG_SHORT_LEN 4    // skp and eios

// 8b/10b symbol values
`define OSG_SYM_COM 8'hBC  // K28.5
`define OSG_SYM_PAD 8'hF7  // K23.7
`define OSG_SYM_SKP 8'h1C  // K28.0
`define OSG_SYM_IDL 8'h7C  // K28.3

// training set identifiers, D symbols
`define OSG_TS1_ID 8'h4A
`define OSG_TS2_ID 8'h45

`endif

// ==== common/os_gen_pkg.sv ====
`default_nettype none

`include "os_gen_macros.svh"

package os_gen_pkg;

   typedef enum logic [1:0] {
      OS_TS1  = 2'd0,
      OS_TS2  = 2'd1,
      OS_SKP  = 2'd2,
      OS_EIOS = 2'd3
   } os_type_e;

   // content of the lane number field in a training set
   typedef enum logic [1:0] {
      LANE_PAD        = 2'd0,
      LANE_SEQUENTIAL = 2'd1,
      LANE_REVERSED   = 2'd2
   } lane_mode_e;

   typedef struct packed {
      os_type_e   os_type;
      lane_mode_e lane_mode;
      logic [7:0] link_number;  // 0 means no link number yet
      logic [2:0] rate;
      logic       loopback;
   } os_request_t;

   typedef struct packed {
      logic       k;     // control character
      logic [7:0] data;
   } os_symbol_t;

   typedef struct packed {
      os_type_e   os_type;
      lane_mode_e lane_mode;
      os_symbol_t link_sym;   // link number or pad
      logic [7:0] rate_byte;  // data rate identifier
      logic [7:0] ctrl_byte;  // training control
   } os_decoded_t;

   // byte n is symbol slot n / lanes on lane n % lanes
   typedef struct packed {
      logic [`OSG_LANES*`OSG_SYMS_PER_CLK*8-1:0] data;
      logic [`OSG_LANES*`OSG_SYMS_PER_CLK-1:0]   datak;
      logic                                      datavalid;
   } pipe_tx_t;

   typedef logic [3:0] sym_index_t;

endpackage

`default_nettype wire

// ==== rtl/os_request_regs.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "os_gen_macros.svh"

module os_request_regs (
   input  wire                     pclk,
   input  wire                     reset_n,
   input  logic                    load,
   input  os_gen_pkg::os_request_t request,
   output os_gen_pkg::os_decoded_t decoded
);
   import os_gen_pkg::*;

   os_decoded_t decoded_next;

   always_comb begin
      decoded_next.os_type   = request.os_type;
      decoded_next.lane_mode = request.lane_mode;

      if (request.link_number == 8'h00) begin
         decoded_next.link_sym = '{k: 1'b1, data: `OSG_SYM_PAD};  // link not yet assigned
      end else begin
         decoded_next.link_sym = '{k: 1'b0, data: request.link_number};
      end

      case (request.rate)
         3'd1:    decoded_next.rate_byte = 8'h02;
         3'd2:    decoded_next.rate_byte = 8'h04;
         3'd3:    decoded_next.rate_byte = 8'h08;
         3'd4:    decoded_next.rate_byte = 8'h10;
         default: decoded_next.rate_byte = 8'h20;
      endcase

      decoded_next.ctrl_byte = request.loopback ? 8'h04 : 8'h00;  // bit 2 is loopback
   end

   always_ff @(posedge pclk) begin
      if (!reset_n) begin
         decoded <= '0;
      end else if (load) begin
         decoded <= decoded_next;
      end
   end

endmodule

`default_nettype wire

// ==== os_gen/os_sequencer.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "os_gen_macros.svh"

module os_sequencer (
   input  wire                    pclk,
   input  wire                    reset_n,
   input  logic                   start,
   input  os_gen_pkg::os_type_e   os_type,
   output logic                   load,
   output logic                   active,
   output os_gen_pkg::sym_index_t index,
   output logic                   last
);
   import os_gen_pkg::*;

   // index of the first symbol of the final beat
   localparam sym_index_t TS_LAST    = sym_index_t'(`OSG_TS_LEN - `OSG_SYMS_PER_CLK);
   localparam sym_index_t SHORT_LAST = sym_index_t'(`OSG_SHORT_LEN - `OSG_SYMS_PER_CLK);
   localparam sym_index_t STEP       = sym_index_t'(`OSG_SYMS_PER_CLK);

   logic       is_ts;
   sym_index_t final_index;

   assign is_ts       = (os_type == OS_TS1) || (os_type == OS_TS2);
   assign final_index = is_ts ? TS_LAST : SHORT_LAST;
   assign last        = active && (index == final_index);

   // the final beat frees the sequencer, so back to back sets have no gap
   assign load = start && (!active || last);

   always_ff @(posedge pclk) begin
      if (!reset_n) begin
         active <= 1'b0;
         index  <= '0;
      end else if (load) begin
         active <= 1'b1;
         index  <= '0;
      end else if (active) begin
         if (last) begin
            active <= 1'b0;
            index  <= '0;
         end else begin
            index <= index + STEP;  // one beat of symbols
         end
      end
   end

endmodule

`default_nettype wire

// ==== os_gen/os_symbol_table.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "os_gen_macros.svh"

module os_symbol_table (
   input  os_gen_pkg::os_decoded_t decoded,
   input  os_gen_pkg::sym_index_t  index,
   output os_gen_pkg::os_symbol_t [`OSG_SYMS_PER_CLK-1:0][`OSG_LANES-1:0] symbols
);
   import os_gen_pkg::*;

   // lane number field of symbol 2
   function automatic os_symbol_t lane_sym(input lane_mode_e mode, input int lane);
      os_symbol_t sym;
      case (mode)
         LANE_SEQUENTIAL: sym = '{k: 1'b0, data: 8'(lane)};
         LANE_REVERSED:   sym = '{k: 1'b0, data: 8'(`OSG_LANES - 1 - lane)};
         default:         sym = '{k: 1'b1, data: `OSG_SYM_PAD};
      endcase
      return sym;
   endfunction

   function automatic os_symbol_t sym_at(input os_decoded_t dec, input sym_index_t pos,
                                         input int lane);
      os_symbol_t sym;
      logic [7:0] ts_id;
      ts_id = (dec.os_type == OS_TS2) ? `OSG_TS2_ID : `OSG_TS1_ID;
      if (dec.os_type == OS_TS1 || dec.os_type == OS_TS2) begin
         case (pos)
            4'd0:    sym = '{k: 1'b1, data: `OSG_SYM_COM};
            4'd1:    sym = dec.link_sym;
            4'd2:    sym = lane_sym(dec.lane_mode, lane);
            4'd3:    sym = '{k: 1'b0, data: 8'h00};  // n_fts
            4'd4:    sym = '{k: 1'b0, data: dec.rate_byte};
            4'd5:    sym = '{k: 1'b0, data: dec.ctrl_byte};
            default: sym = '{k: 1'b0, data: ts_id};  // symbols 6 to 15
         endcase
      end else if (pos == 4'd0) begin
         sym = '{k: 1'b1, data: `OSG_SYM_COM};
      end else if (dec.os_type == OS_SKP) begin
         sym = '{k: 1'b1, data: `OSG_SYM_SKP};
      end else begin
         sym = '{k: 1'b1, data: `OSG_SYM_IDL};  // eios
      end
      return sym;
   endfunction

   always_comb begin
      for (int s = 0; s < `OSG_SYMS_PER_CLK; s++) begin
         for (int l = 0; l < `OSG_LANES; l++) begin
            symbols[s][l] = sym_at(decoded, sym_index_t'(index + s), l);
         end
      end
   end

endmodule

`default_nettype wire

// ==== os_gen/os_lane_packer.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "os_gen_macros.svh"

module os_lane_packer (
   input  wire                  pclk,
   input  wire                  reset_n,
   input  logic                 active,
   input  logic                 last,
   input  os_gen_pkg::os_symbol_t [`OSG_SYMS_PER_CLK-1:0][`OSG_LANES-1:0] symbols,
   output os_gen_pkg::pipe_tx_t pipe_tx,
   output logic                 busy,
   output logic                 finish
);
   import os_gen_pkg::*;

   pipe_tx_t beat_next;

   always_comb begin
      beat_next = '0;  // idle beats are all zero
      if (active) begin
         beat_next.datavalid = 1'b1;
         for (int s = 0; s < `OSG_SYMS_PER_CLK; s++) begin
            for (int l = 0; l < `OSG_LANES; l++) begin
               beat_next.data[(s*`OSG_LANES + l)*8 +: 8] = symbols[s][l].data;
               beat_next.datak[s*`OSG_LANES + l]         = symbols[s][l].k;
            end
         end
      end
   end

   always_ff @(posedge pclk) begin
      if (!reset_n) begin
         pipe_tx <= '0;
         busy    <= 1'b0;
         finish  <= 1'b0;
      end else begin
         pipe_tx <= beat_next;
         busy    <= active && !last;
         finish  <= active && last;  // one pulse with the final beat
      end
   end

endmodule

`default_nettype wire

// ==== rtl/os_gen_top.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "os_gen_macros.svh"

module os_gen_top (
   input  wire                     pclk,
   input  wire                     reset_n,
   input  logic                    start,
   input  os_gen_pkg::os_request_t request,
   output os_gen_pkg::pipe_tx_t    pipe_tx,
   output logic                    busy,
   output logic                    finish
);
   import os_gen_pkg::*;

   logic        load;
   logic        active;
   logic        last;
   sym_index_t  index;
   os_decoded_t decoded;
   os_symbol_t [`OSG_SYMS_PER_CLK-1:0][`OSG_LANES-1:0] symbols;

   os_request_regs request_regs_i (
      .pclk    (pclk),
      .reset_n (reset_n),
      .load    (load),
      .request (request),
      .decoded (decoded)
   );

   os_sequencer sequencer_i (
      .pclk    (pclk),
      .reset_n (reset_n),
      .start   (start),
      .os_type (decoded.os_type),  // picks the set length
      .load    (load),
      .active  (active),
      .index   (index),
      .last    (last)
   );

   os_symbol_table symbol_table_i (
      .decoded (decoded),
      .index   (index),
      .symbols (symbols)
   );

   os_lane_packer lane_packer_i (
      .pclk    (pclk),
      .reset_n (reset_n),
      .active  (active),
      .last    (last),
      .symbols (symbols),
      .pipe_tx (pipe_tx),
      .busy    (busy),
      .finish  (finish)
   );

endmodule

`default_nettype wire

// ==== verification/os_gen_clk.sv ====
`default_nettype none
`timescale 1ns/100ps

module os_gen_clk (
   output logic pclk,
   output logic reset_n
);
   localparam int HALF_PERIOD  = 2;  // 4 ns pclk
   localparam int RESET_CYCLES = 4;

   initial begin
      pclk    = 1'b0;
      reset_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge pclk);
      reset_n <= 1'b1;  // released on a rising edge like the other inputs
   end

   always #HALF_PERIOD pclk = ~pclk;

endmodule

`default_nettype wire

// ==== verification/os_gen_checker.sv ====
`default_nettype none
`timescale 1ns/100ps

module os_gen_checker (
   input wire                  pclk,
   input wire                  reset_n,
   input os_gen_pkg::pipe_tx_t pipe_tx,
   input logic                 busy,
   input logic                 finish
);

   // the final beat always carries symbols
   finish_has_data: assert property (@(posedge pclk) disable iff (!reset_n)
      finish |-> pipe_tx.datavalid)
      else $error("finish high on a beat without datavalid");

   busy_finish_apart: assert property (@(posedge pclk) disable iff (!reset_n)
      !(busy && finish))
      else $error("busy and finish high in the same cycle");

   idle_beat_zero: assert property (@(posedge pclk) disable iff (!reset_n)
      !pipe_tx.datavalid |-> (pipe_tx.data == '0 && pipe_tx.datak == '0))
      else $error("data or datak not zero on an idle beat");

   // first cycle out of reset
   reset_exit_idle: assert property (@(posedge pclk)
      $rose(reset_n) |-> !pipe_tx.datavalid)
      else $error("datavalid high in the first cycle after reset");

endmodule

bind os_gen_top os_gen_checker checker_i (
   .pclk    (pclk),
   .reset_n (reset_n),
   .pipe_tx (pipe_tx),
   .busy    (busy),
   .finish  (finish)
);

`default_nettype wire

// ==== verification/os_gen_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "os_gen_macros.svh"

module os_gen_tb;
   import os_gen_pkg::*;

   localparam int LANES      = `OSG_LANES;
   localparam int SPC        = `OSG_SYMS_PER_CLK;
   localparam int WAIT_MAX   = 100;  // cycles for any single wait
   localparam int NUM_RANDOM = 4;

   typedef struct packed {
      os_request_t req;
      logic [4:0]  set_len;  // expected symbols per lane
      logic        poke;     // extra start while the set is busy
   } vector_t;

   logic        pclk;
   logic        reset_n;
   logic        start;
   os_request_t request;
   pipe_tx_t    pipe_tx;
   logic        busy;
   logic        finish;
   vector_t     vectors[$];

   os_gen_clk clk_gen_i (
      .pclk    (pclk),
      .reset_n (reset_n)
   );

   os_gen_top dut_i (
      .pclk    (pclk),
      .reset_n (reset_n),
      .start   (start),
      .request (request),
      .pipe_tx (pipe_tx),
      .busy    (busy),
      .finish  (finish)
   );

   task automatic check_eq(input string what, input logic [31:0] got,
                           input logic [31:0] expected);
      if (got !== expected) begin
         $display("** Error at %0t: %s: got 0x%0h, expected 0x%0h", $time, what, got, expected);
         $display("TEST FAILED");
         $fatal(1, "value mismatch in %s", what);
      end
   endtask

   task automatic abort_timeout(input string what);
      $display("timeout: no %s within %0d cycles", what, WAIT_MAX);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped on a timeout");
   endtask

   // rate codes 1 to 4 give one-hot bytes 02 to 10
   function automatic logic [7:0] rate_code_byte(input logic [2:0] rate);
      logic [7:0] rate_byte;
      if (rate >= 3'd1 && rate <= 3'd4) begin
         rate_byte = 8'h01 << rate;
      end else begin
         rate_byte = 8'h20;
      end
      return rate_byte;
   endfunction

   // expected {k, byte} of symbol pos on one lane
   function automatic logic [8:0] model_sym(input os_request_t req, input int pos,
                                            input int lane);
      logic [8:0] sym;
      if (req.os_type == OS_TS1 || req.os_type == OS_TS2) begin
         case (pos)
            0: sym = {1'b1, 8'hBC};
            1: sym = (req.link_number == 8'h00) ? {1'b1, 8'hF7} : {1'b0, req.link_number};
            2: begin
               if (req.lane_mode == LANE_SEQUENTIAL) begin
                  sym = {1'b0, 8'(lane)};
               end else if (req.lane_mode == LANE_REVERSED) begin
                  sym = {1'b0, 8'(LANES - 1 - lane)};
               end else begin
                  sym = {1'b1, 8'hF7};
               end
            end
            3: sym = {1'b0, 8'h00};
            4: sym = {1'b0, rate_code_byte(req.rate)};
            5: sym = {1'b0, (req.loopback ? 8'h04 : 8'h00)};
            default: sym = {1'b0, ((req.os_type == OS_TS1) ? 8'h4A : 8'h45)};
         endcase
      end else if (pos == 0) begin
         sym = {1'b1, 8'hBC};
      end else if (req.os_type == OS_SKP) begin
         sym = {1'b1, 8'h1C};
      end else begin
         sym = {1'b1, 8'h7C};  // eios
      end
      return sym;
   endfunction

   task automatic add_vector(input os_type_e os_type, input lane_mode_e lane_mode,
                             input logic [7:0] link, input logic [2:0] rate,
                             input logic loopback, input int set_len, input logic poke);
      vector_t vec;
      vec.req.os_type     = os_type;
      vec.req.lane_mode   = lane_mode;
      vec.req.link_number = link;
      vec.req.rate        = rate;
      vec.req.loopback    = loopback;
      vec.set_len         = 5'(set_len);
      vec.poke            = poke;
      vectors.push_back(vec);
   endtask

   task automatic check_idle(input string label);
      check_eq({label, " datavalid"}, 32'(pipe_tx.datavalid), 32'd0);
      check_eq({label, " busy"}, 32'(busy), 32'd0);
      check_eq({label, " finish"}, 32'(finish), 32'd0);
      check_eq({label, " datak"}, 32'(pipe_tx.datak), 32'd0);
      for (int b = 0; b < LANES * SPC; b++) begin
         check_eq($sformatf("%s data byte %0d", label, b), 32'(pipe_tx.data[b*8 +: 8]), 32'd0);
      end
   endtask

   task automatic run_set(input int num, input vector_t vec);
      int         wait_cnt;
      int         beats;
      int         nbeats;
      logic [8:0] exp_sym;
      logic       done;
      nbeats   = int'(vec.set_len) / SPC;
      wait_cnt = 0;
      @(negedge pclk);
      while (busy) begin
         if (wait_cnt == WAIT_MAX) abort_timeout("drop of busy");
         wait_cnt++;
         @(negedge pclk);
      end

      @(posedge pclk);
      request <= vec.req;
      start   <= 1'b1;

      beats    = 0;
      wait_cnt = 0;
      done     = 1'b0;
      while (!done) begin
         @(posedge pclk);
         start <= vec.poke && (beats == 1);  // lands in the middle of the set
         @(negedge pclk);
         if (pipe_tx.datavalid) begin
            for (int s = 0; s < SPC; s++) begin
               for (int l = 0; l < LANES; l++) begin
                  exp_sym = model_sym(vec.req, beats * SPC + s, l);
                  check_eq($sformatf("set %0d beat %0d slot %0d lane %0d data", num, beats, s, l),
                           32'(pipe_tx.data[(s*LANES + l)*8 +: 8]), 32'(exp_sym[7:0]));
                  check_eq($sformatf("set %0d beat %0d slot %0d lane %0d datak", num, beats, s, l),
                           32'(pipe_tx.datak[s*LANES + l]), 32'(exp_sym[8]));
               end
            end
            check_eq($sformatf("set %0d beat %0d busy", num, beats), 32'(busy),
                     32'(beats != nbeats - 1));
            done = finish;
            beats++;
         end else if (beats != 0) begin
            check_eq($sformatf("set %0d datavalid after beat %0d", num, beats), 32'd0, 32'd1);
         end
         if (wait_cnt == WAIT_MAX) abort_timeout("finish");
         wait_cnt++;
      end
      check_eq($sformatf("set %0d beat count", num), 32'(beats), 32'(nbeats));

      @(posedge pclk);
      @(negedge pclk);
      check_idle($sformatf("after set %0d", num));
   endtask

   initial begin
      os_type_e os_type;
      int       cnt;
      start   = 1'b0;
      request = '0;
      void'($urandom(32'he1c07933));

      cnt = 0;
      while (reset_n !== 1'b1) begin
         if (cnt == WAIT_MAX) abort_timeout("release of reset_n");
         cnt++;
         @(negedge pclk);
      end
      check_idle("after reset");

      // type, lane mode, link, rate, loopback, set length, extra start
      add_vector(OS_TS1,  LANE_SEQUENTIAL, 8'h05, 3'd1, 1'b1, 16, 1'b0);
      add_vector(OS_TS1,  LANE_REVERSED,   8'hA3, 3'd3, 1'b0, 16, 1'b1);
      add_vector(OS_TS2,  LANE_PAD,        8'h00, 3'd2, 1'b0, 16, 1'b0);
      add_vector(OS_TS2,  LANE_REVERSED,   8'h01, 3'd4, 1'b1, 16, 1'b0);
      add_vector(OS_TS2,  LANE_SEQUENTIAL, 8'hFF, 3'd7, 1'b0, 16, 1'b1);
      add_vector(OS_SKP,  LANE_PAD,        8'h03, 3'd0, 1'b0, 4,  1'b0);
      add_vector(OS_EIOS, LANE_SEQUENTIAL, 8'h09, 3'd1, 1'b1, 4,  1'b0);
      add_vector(OS_TS1,  LANE_PAD,        8'h00, 3'd0, 1'b0, 16, 1'b0);
      for (int i = 0; i < NUM_RANDOM; i++) begin
         os_type = os_type_e'(2'(i));
         add_vector(os_type, lane_mode_e'(2'($urandom_range(2, 0))), 8'($urandom),
                    3'($urandom), 1'($urandom), (i < 2) ? 16 : 4, 1'b0);
      end

      foreach (vectors[i]) begin
         run_set(i, vectors[i]);
      end

      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/os_gen_pkg.sv
rtl/os_request_regs.sv
os_gen/os_sequencer.sv
os_gen/os_symbol_table.sv
os_gen/os_lane_packer.sv
rtl/os_gen_top.sv
verification/os_gen_clk.sv
verification/os_gen_checker.sv
verification/os_gen_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ordered-set generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module os_gen_tb \
   -Mdir obj_dir -o os_gen_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit $status
fi

./obj_dir/os_gen_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

exit 0
